// ==== icache_cfg.svh ====
/*
 * cache geometry macros
 * tag width, index width and the word-address PC width built from them
 */

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// upper word-address bits kept in every entry
`define ICACHE_TAG_WIDTH 6

// word-address bits that select an entry
`define ICACHE_INDEX_WIDTH 6

// word-address PC, tag on top of index
`define ICACHE_PC_WIDTH (`ICACHE_TAG_WIDTH + `ICACHE_INDEX_WIDTH)

`endif

// ==== icache_pkg.sv ====
/*
 * shared types for the fetch subsystem
 * opcodes, jump kinds, fetch states, cache entry layout
 * and the RISC-V immediate extract and inject helpers
 */

`include "icache_cfg.svh"

package icache_pkg;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // low byte-offset bits handled by the predecode adders
  localparam int BIMM_LOW_W = 12;
  localparam int JIMM_LOW_W = 20;

  typedef enum logic [1:0] {
    JK_NONE   = 2'd0,
    JK_BRANCH = 2'd1,
    JK_JAL    = 2'd2
  } jump_kind_e;

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    RUN  = 2'b01,
    MISS = 2'b10
  } fetch_state_e;

  typedef struct packed {
    logic                         lower_sign;
    logic                         lower_cout;
    logic [`ICACHE_TAG_WIDTH-1:0] tag;
    logic [31:0]                  instr;
  } icache_entry_t;

  function automatic jump_kind_e decode_kind(input logic [31:0] instr);
    if (instr[6:0] == OPC_BRANCH) return JK_BRANCH;
    if (instr[6:0] == OPC_JAL) return JK_JAL;
    return JK_NONE;
  endfunction

  // B-type byte offset, bit 0 always zero
  function automatic logic [12:0] bimm_extract(input logic [31:0] instr);
    return {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  // J-type byte offset, bit 0 always zero
  function automatic logic [20:0] jimm_extract(input logic [31:0] instr);
    return {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

  // sign bit instr[31] is left alone on both inject paths
  function automatic logic [31:0] bimm_inject(input logic [31:0] instr,
                                              input logic [11:0] low);
    logic [31:0] res;
    res        = instr;
    res[7]     = low[11];
    res[30:25] = low[10:5];
    res[11:8]  = low[4:1];
    return res;
  endfunction

  function automatic logic [31:0] jimm_inject(input logic [31:0] instr,
                                              input logic [19:0] low);
    logic [31:0] res;
    res        = instr;
    res[19:12] = low[19:12];
    res[20]    = low[11];
    res[30:21] = low[10:1];
    return res;
  endfunction

endpackage

// ==== icache_fill_if.sv ====
/*
 * write port of the instruction cache
 * one entry written on each edge with wr_en high
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

interface icache_fill_if;

  logic                           wr_en;
  logic [`ICACHE_INDEX_WIDTH-1:0] wr_index;
  logic [`ICACHE_TAG_WIDTH-1:0]   wr_tag;
  logic [31:0]                    wr_instr;

  // loader side
  modport master (
    output wr_en,
    output wr_index,
    output wr_tag,
    output wr_instr
  );

  // cache side
  modport slave (
    input wr_en,
    input wr_index,
    input wr_tag,
    input wr_instr
  );

endinterface

// ==== jump_predecode.sv ====
/*
 * write-side jump predecoder
 * adds the branch or JAL offset to the slot byte address, puts the low sum
 * back into the immediate field and keeps the offset sign and the carry out
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

module jump_predecode (
  input  logic [`ICACHE_INDEX_WIDTH-1:0] wr_index_i,
  input  logic [`ICACHE_TAG_WIDTH-1:0]   wr_tag_i,
  input  logic [31:0]                    instr_i,
  output icache_pkg::icache_entry_t      entry_o
);

  localparam int BYTE_W = `ICACHE_PC_WIDTH + 2;
  localparam int BL     = icache_pkg::BIMM_LOW_W;
  localparam int JL     = icache_pkg::JIMM_LOW_W;

  icache_pkg::jump_kind_e kind;
  logic [BYTE_W-1:0]      slot_addr;
  logic [12:0]            b_imm_val;
  logic [20:0]            j_imm_val;
  logic [BL:0]            b_sum;
  logic [JL:0]            j_sum;

  assign kind = icache_pkg::decode_kind(instr_i);

  // byte address of the slot being written
  assign slot_addr = {wr_tag_i, wr_index_i, 2'b00};

  assign b_imm_val = icache_pkg::bimm_extract(instr_i);
  assign j_imm_val = icache_pkg::jimm_extract(instr_i);

  // ----------------------------------------
  // narrow adders, low offset bits only
  // ----------------------------------------
  // the sign bit stays out of the sum, the read side applies it to the
  // high PC part together with the carry
  assign b_sum = {1'b0, BL'(slot_addr)} + {1'b0, b_imm_val[BL-1:0]};
  assign j_sum = {1'b0, JL'(slot_addr)} + {1'b0, j_imm_val[JL-1:0]};

  always_comb begin
    entry_o.tag = wr_tag_i;
    case (kind)
      icache_pkg::JK_BRANCH: begin
        entry_o.instr      = icache_pkg::bimm_inject(instr_i, b_sum[BL-1:0]);
        entry_o.lower_sign = b_imm_val[12];
        entry_o.lower_cout = b_sum[BL];
      end
      icache_pkg::JK_JAL: begin
        entry_o.instr      = icache_pkg::jimm_inject(instr_i, j_sum[JL-1:0]);
        entry_o.lower_sign = j_imm_val[20];
        entry_o.lower_cout = j_sum[JL];
      end
      default: begin
        entry_o.instr      = instr_i;
        entry_o.lower_sign = 1'b0;
        entry_o.lower_cout = 1'b0;
      end
    endcase
  end

endmodule

// ==== icache_array.sv ====
/*
 * single-port entry memory for the instruction cache
 * registered read, write without read-through
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_array (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           en_i,
  input  logic                           wr_i,
  input  logic [`ICACHE_INDEX_WIDTH-1:0] addr_i,
  input  icache_pkg::icache_entry_t      wdata_i,
  output icache_pkg::icache_entry_t      rdata_o
);

  localparam int DEPTH = 1 << `ICACHE_INDEX_WIDTH;

  icache_pkg::icache_entry_t mem [0:DEPTH-1];

  // no access of either kind while reset is held
  always_ff @(posedge clk_i) begin
    if (en_i && !rst_i) begin
      if (wr_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== icache.sv ====
/*
 * direct-mapped instruction cache
 * predecode on write, tag compare and jump target rebuild on read
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache (
  input  logic                         clk_i,
  input  logic                         rst_i,
  icache_fill_if.slave                 fill,
  input  logic                         fetch_en_i,
  input  logic [`ICACHE_PC_WIDTH-1:0]  fetch_pc_i,
  output logic [31:0]                  instr_o,
  output icache_pkg::jump_kind_e       jump_kind_o,
  output logic                         branch_back_o,
  output logic [`ICACHE_PC_WIDTH-1:0]  jump_target_o,
  output logic                         hit_o,
  output logic [`ICACHE_PC_WIDTH-1:0]  pc_o
);

  localparam int BYTE_W = `ICACHE_PC_WIDTH + 2;
  localparam int BL     = icache_pkg::BIMM_LOW_W;
  localparam int JL     = icache_pkg::JIMM_LOW_W;

  icache_pkg::icache_entry_t      wr_entry;
  icache_pkg::icache_entry_t      rd_entry;
  logic [`ICACHE_INDEX_WIDTH-1:0] index;
  logic [`ICACHE_PC_WIDTH-1:0]    pc_q;
  logic                           rd_q;
  logic [12:0]                    b_imm_rd;
  logic [20:0]                    j_imm_rd;
  logic                           sel_n1;
  logic                           sel_p1;
  logic [BYTE_W-1:0]              b_target;
  logic [BYTE_W-1:0]              j_target;

  // high part of the PC moved by one, then the stored low bits appended
  function automatic logic [BYTE_W-1:0] rebuild(input logic [BYTE_W-1:0] pc_b,
                                                input int                low_w,
                                                input logic [BYTE_W-1:0] low,
                                                input logic              dec,
                                                input logic              inc);
    logic [BYTE_W-1:0] high;
    high = pc_b >> low_w;
    if (dec) begin
      high = high - 1'b1;
    end else if (inc) begin
      high = high + 1'b1;
    end
    return (high << low_w) | low;
  endfunction

  jump_predecode u_predecode (
    .wr_index_i (fill.wr_index),
    .wr_tag_i   (fill.wr_tag),
    .instr_i    (fill.wr_instr),
    .entry_o    (wr_entry)
  );

  // writes take the port over fetch reads
  assign index = fill.wr_en ? fill.wr_index : fetch_pc_i[`ICACHE_INDEX_WIDTH-1:0];

  icache_array u_array (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .en_i    (fill.wr_en | fetch_en_i),
    .wr_i    (fill.wr_en),
    .addr_i  (index),
    .wdata_i (wr_entry),
    .rdata_o (rd_entry)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= fetch_en_i & ~fill.wr_en;
    end
  end

  // PC of the read now in the array output register
  always_ff @(posedge clk_i) begin
    if (fetch_en_i && !fill.wr_en) begin
      pc_q <= fetch_pc_i;
    end
  end

  // ----------------------------------------
  // target rebuild
  // ----------------------------------------
  // sign 1, carry 0 -> high - 1 ; sign 0, carry 1 -> high + 1 ; else same
  assign sel_n1 = rd_entry.lower_sign & ~rd_entry.lower_cout;
  assign sel_p1 = ~rd_entry.lower_sign & rd_entry.lower_cout;

  assign b_imm_rd = icache_pkg::bimm_extract(rd_entry.instr);
  assign j_imm_rd = icache_pkg::jimm_extract(rd_entry.instr);

  assign b_target = rebuild({pc_q, 2'b00}, BL, BYTE_W'(b_imm_rd[BL-1:0]), sel_n1, sel_p1);
  assign j_target = rebuild({pc_q, 2'b00}, JL, BYTE_W'(j_imm_rd[JL-1:0]), sel_n1, sel_p1);

  assign instr_o       = rd_entry.instr;
  assign jump_kind_o   = icache_pkg::decode_kind(rd_entry.instr);
  assign branch_back_o = rd_entry.lower_sign;
  assign jump_target_o = (jump_kind_o == icache_pkg::JK_JAL) ? j_target[BYTE_W-1:2]
                                                             : b_target[BYTE_W-1:2];
  assign hit_o         = rd_q && (rd_entry.tag == pc_q[`ICACHE_PC_WIDTH-1:`ICACHE_INDEX_WIDTH]);
  assign pc_o          = pc_q;

  // loader and PC counter must never share the port
  a_fill_fetch_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(fill.wr_en && fetch_en_i));

endmodule

// ==== pc_counter.sv ====
/*
 * fetch PC register
 * start, sequential step, redirect and halt of the fetch strobe
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

module pc_counter (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        start_i,
  input  logic [`ICACHE_PC_WIDTH-1:0] start_pc_i,
  input  logic                        redirect_i,
  input  logic [`ICACHE_PC_WIDTH-1:0] redirect_pc_i,
  input  logic                        halt_i,
  output logic [`ICACHE_PC_WIDTH-1:0] pc_o,
  output logic                        fetch_en_o
);

  logic [`ICACHE_PC_WIDTH-1:0] pc_q;
  logic                        run_q;

  // halt wins over start and redirect
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q <= 1'b0;
      pc_q  <= '0;
    end else if (halt_i) begin
      run_q <= 1'b0;
    end else if (!run_q) begin
      if (start_i) begin
        run_q <= 1'b1;
        pc_q  <= start_pc_i;
      end
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else begin
      pc_q <= pc_q + 1'b1;
    end
  end

  assign pc_o       = pc_q;
  assign fetch_en_o = run_q;

endmodule

// ==== fetch_ctrl.sv ====
/*
 * fetch controller FSM over IDLE, RUN and MISS
 * loader write path, in-flight tracking, static branch prediction
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

module fetch_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        load_en_i,
  input  logic [`ICACHE_PC_WIDTH-1:0] load_addr_i,
  input  logic [31:0]                 load_instr_i,
  input  logic                        start_i,
  input  logic                        stop_i,
  icache_fill_if.master               fill,
  input  logic [31:0]                 instr_i,
  input  icache_pkg::jump_kind_e      jump_kind_i,
  input  logic                        branch_back_i,
  input  logic [`ICACHE_PC_WIDTH-1:0] jump_target_i,
  input  logic                        hit_i,
  output logic                        redirect_o,
  output logic [`ICACHE_PC_WIDTH-1:0] redirect_pc_o,
  output logic                        halt_o,
  output logic                        fetch_valid_o,
  output logic                        miss_o,
  output logic                        busy_o
);

  icache_pkg::fetch_state_e state_q;
  icache_pkg::fetch_state_e state_d;
  logic                     inflight_q;
  logic                     delivered;
  logic                     taken;

  // loader address split into index and tag
  assign fill.wr_en    = load_en_i && (state_q == icache_pkg::IDLE);
  assign fill.wr_index = load_addr_i[`ICACHE_INDEX_WIDTH-1:0];
  assign fill.wr_tag   = load_addr_i[`ICACHE_PC_WIDTH-1:`ICACHE_INDEX_WIDTH];
  assign fill.wr_instr = load_instr_i;

  assign delivered     = (state_q == icache_pkg::RUN) && inflight_q;
  assign fetch_valid_o = delivered && hit_i;
  assign miss_o        = delivered && !hit_i;

  // JAL always, branches only backward
  assign taken = (jump_kind_i == icache_pkg::JK_JAL) ||
                 ((jump_kind_i == icache_pkg::JK_BRANCH) && branch_back_i);

  assign redirect_o    = fetch_valid_o && taken;
  assign redirect_pc_o = jump_target_i;
  assign halt_o        = (state_d != icache_pkg::RUN);
  assign busy_o        = (state_q != icache_pkg::IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::IDLE: if (start_i) state_d = icache_pkg::RUN;
      icache_pkg::RUN: begin
        if (stop_i) begin
          state_d = icache_pkg::IDLE;
        end else if (miss_o) begin
          state_d = icache_pkg::MISS;
        end
      end
      icache_pkg::MISS: if (stop_i) state_d = icache_pkg::IDLE;
      default: state_d = icache_pkg::IDLE;
    endcase
  end

  // the fetch issued alongside a redirect is dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= icache_pkg::IDLE;
      inflight_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      inflight_q <= (state_q == icache_pkg::RUN) && (state_d == icache_pkg::RUN) &&
                    !redirect_o;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_load_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    load_en_i |-> state_q == icache_pkg::IDLE);

  // stored sign from the predecoder agrees with the untouched sign bit
  a_sign_agree: assert property (@(posedge clk_i) disable iff (rst_i)
    fetch_valid_o && (jump_kind_i == icache_pkg::JK_BRANCH) |->
      branch_back_i == instr_i[31]);

endmodule

// ==== icache_fetch_top.sv ====
/*
 * fetch subsystem top level
 * controller, PC counter and instruction cache
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_fetch_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        load_en_i,
  input  logic [`ICACHE_PC_WIDTH-1:0] load_addr_i,
  input  logic [31:0]                 load_instr_i,
  input  logic                        start_i,
  input  logic [`ICACHE_PC_WIDTH-1:0] start_pc_i,
  input  logic                        stop_i,
  output logic                        fetch_valid_o,
  output logic [`ICACHE_PC_WIDTH-1:0] fetch_pc_o,
  output logic [31:0]                 fetch_instr_o,
  output logic                        miss_o,
  output logic                        busy_o
);

  icache_fill_if fill_if ();

  icache_pkg::jump_kind_e      jump_kind;
  logic                        branch_back;
  logic [`ICACHE_PC_WIDTH-1:0] jump_target;
  logic                        hit;
  logic                        redirect;
  logic [`ICACHE_PC_WIDTH-1:0] redirect_pc;
  logic                        halt;
  logic [`ICACHE_PC_WIDTH-1:0] pc;
  logic                        fetch_en;

  fetch_ctrl u_fetch_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .load_en_i     (load_en_i),
    .load_addr_i   (load_addr_i),
    .load_instr_i  (load_instr_i),
    .start_i       (start_i),
    .stop_i        (stop_i),
    .fill          (fill_if.master),
    .instr_i       (fetch_instr_o),
    .jump_kind_i   (jump_kind),
    .branch_back_i (branch_back),
    .jump_target_i (jump_target),
    .hit_i         (hit),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .halt_o        (halt),
    .fetch_valid_o (fetch_valid_o),
    .miss_o        (miss_o),
    .busy_o        (busy_o)
  );

  pc_counter u_pc_counter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (start_i),
    .start_pc_i    (start_pc_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .halt_i        (halt),
    .pc_o          (pc),
    .fetch_en_o    (fetch_en)
  );

  icache u_icache (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fill          (fill_if.slave),
    .fetch_en_i    (fetch_en),
    .fetch_pc_i    (pc),
    .instr_o       (fetch_instr_o),
    .jump_kind_o   (jump_kind),
    .branch_back_o (branch_back),
    .jump_target_o (jump_target),
    .hit_o         (hit),
    .pc_o          (fetch_pc_o)
  );

endmodule

// ==== tb_icache_fetch.sv ====
/*
 * testbench for the instruction fetch subsystem
 * program loading, reference fetch model, compare process and timeout
 */

`timescale 1ns/1ps
`include "icache_cfg.svh"

module tb_icache_fetch;

  localparam int PCW   = `ICACHE_PC_WIDTH;
  localparam int IDXW  = `ICACHE_INDEX_WIDTH;
  localparam int TAGW  = `ICACHE_TAG_WIDTH;
  localparam int LINES = 1 << IDXW;
  // cycles of all phases together with the loads
  localparam int TEST_CYCLES = 400;
  localparam int CYCLE_LIMIT = TEST_CYCLES * 2;

  logic            clk_i;
  logic            rst_i;
  logic            load_en_i;
  logic [PCW-1:0]  load_addr_i;
  logic [31:0]     load_instr_i;
  logic            start_i;
  logic [PCW-1:0]  start_pc_i;
  logic            stop_i;
  logic            fetch_valid_o;
  logic [PCW-1:0]  fetch_pc_o;
  logic [31:0]     fetch_instr_o;
  logic            miss_o;
  logic            busy_o;

  // shadow of the cache lines as the loader wrote them
  logic [TAGW-1:0] line_tag   [0:LINES-1];
  logic [31:0]     line_instr [0:LINES-1];

  int              cycle_cnt;

  icache_fetch_top DUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .load_en_i     (load_en_i),
    .load_addr_i   (load_addr_i),
    .load_instr_i  (load_instr_i),
    .start_i       (start_i),
    .start_pc_i    (start_pc_i),
    .stop_i        (stop_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o    (fetch_pc_o),
    .fetch_instr_o (fetch_instr_o),
    .miss_o        (miss_o),
    .busy_o        (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic raise_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // byte offset of a B-type or J-type instruction, zero for anything else
  function automatic int jump_offset(input logic [31:0] instr);
    logic [31:0] imm;
    imm = '0;
    if (instr[6:0] == icache_pkg::OPC_BRANCH) begin
      imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    end else if (instr[6:0] == icache_pkg::OPC_JAL) begin
      imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    end
    return int'(imm);
  endfunction

  // JAL always, branches only when the offset points backward
  function automatic logic ref_taken(input logic [31:0] instr);
    if (instr[6:0] == icache_pkg::OPC_JAL) begin
      return 1'b1;
    end
    return (instr[6:0] == icache_pkg::OPC_BRANCH) && (jump_offset(instr) < 0);
  endfunction

  function automatic logic [PCW-1:0] ref_next_pc(input logic [PCW-1:0] pc,
                                                 input logic [31:0]    instr);
    int off_words;
    off_words = jump_offset(instr) >>> 2;
    if (ref_taken(instr)) begin
      return PCW'(int'(pc) + off_words);
    end
    return PCW'(pc + 1);
  endfunction

  // loaded word with the low target bits written into its offset field
  function automatic logic [31:0] ref_instr(input logic [PCW-1:0] pc,
                                            input logic [31:0]    instr);
    logic [31:0] res;
    logic [31:0] sum;
    res = instr;
    sum = 32'({pc, 2'b00}) + 32'(jump_offset(instr));
    if (instr[6:0] == icache_pkg::OPC_BRANCH) begin
      res[7]     = sum[11];
      res[30:25] = sum[10:5];
      res[11:8]  = sum[4:1];
    end else if (instr[6:0] == icache_pkg::OPC_JAL) begin
      res[19:12] = sum[19:12];
      res[20]    = sum[11];
      res[30:21] = sum[10:1];
    end
    return res;
  endfunction

  // ----------------------------------------
  // program words
  // ----------------------------------------
  function automatic logic [31:0] rand_plain();
    logic [31:0] w;
    w = $urandom();
    if (w[6:0] == icache_pkg::OPC_BRANCH || w[6:0] == icache_pkg::OPC_JAL) begin
      w[6:0] = 7'b0010011;
    end
    return w;
  endfunction

  function automatic logic [31:0] make_branch(input int off_words);
    logic [31:0] w;
    logic [12:0] imm;
    w          = $urandom();
    imm        = 13'(off_words * 4);
    w[31]      = imm[12];
    w[7]       = imm[11];
    w[30:25]   = imm[10:5];
    w[11:8]    = imm[4:1];
    w[6:0]     = icache_pkg::OPC_BRANCH;
    return w;
  endfunction

  function automatic logic [31:0] make_jal(input int off_words);
    logic [31:0] w;
    logic [20:0] imm;
    w          = $urandom();
    imm        = 21'(off_words * 4);
    w[31]      = imm[20];
    w[30:21]   = imm[10:1];
    w[20]      = imm[11];
    w[19:12]   = imm[19:12];
    w[6:0]     = icache_pkg::OPC_JAL;
    return w;
  endfunction

  // ----------------------------------------
  // stimulus tasks entered and left 1 ns after a rising edge
  // ----------------------------------------
  task automatic load_word(input logic [PCW-1:0] addr, input logic [31:0] instr);
    load_en_i                  = 1'b1;
    load_addr_i                = addr;
    load_instr_i               = instr;
    line_tag[addr[IDXW-1:0]]   = addr[PCW-1:IDXW];
    line_instr[addr[IDXW-1:0]] = instr;
    @(posedge clk_i);
    #1;
    load_en_i = 1'b0;
  endtask

  // lower index half gets tag_lo, upper half tag_hi
  task automatic fill_cache(input logic [TAGW-1:0] tag_lo, input logic [TAGW-1:0] tag_hi);
    logic [TAGW-1:0] tag;
    for (int i = 0; i < LINES; i++) begin
      tag = (i < LINES / 2) ? tag_lo : tag_hi;
      load_word({tag, IDXW'(i)}, rand_plain());
    end
  endtask

  task automatic start_at(input logic [PCW-1:0] pc);
    start_i    = 1'b1;
    start_pc_i = pc;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
  endtask

  task automatic stop_run();
    stop_i = 1'b1;
    @(posedge clk_i);
    #1;
    stop_i = 1'b0;
  endtask

  task automatic wait_fetches(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk_i);
      if (fetch_valid_o) begin
        seen++;
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_miss();
    do begin
      @(negedge clk_i);
    end while (!miss_o);
    @(posedge clk_i);
    #1;
  endtask

  // ----------------------------------------
  // compare process sampling on the falling edge
  // ----------------------------------------
  initial begin : compare
    icache_pkg::fetch_state_e mstate;
    logic [PCW-1:0]           exp_pc;
    logic [31:0]              raw;
    logic                     active;
    logic                     bubble_due;
    logic                     exp_hit;
    mstate     = icache_pkg::IDLE;
    exp_pc     = '0;
    active     = 1'b0;
    bubble_due = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_i) begin
        mstate = icache_pkg::IDLE;
        active = 1'b0;
      end else begin
        assert (busy_o == (mstate != icache_pkg::IDLE))
          else raise_error($sformatf("Mismatch at %0t: busy_o is %b", $time, busy_o));
        if (!active) begin
          assert (!fetch_valid_o && !miss_o)
            else raise_error("fetch or miss output while no fetch stream runs");
        end else begin
          raw     = line_instr[exp_pc[IDXW-1:0]];
          exp_hit = (line_tag[exp_pc[IDXW-1:0]] == exp_pc[PCW-1:IDXW]);
          if (fetch_valid_o) begin
            assert (!bubble_due && exp_hit)
              else raise_error($sformatf("Mismatch at %0t: fetch where none expected, pc %h",
                                         $time, exp_pc));
            assert (fetch_pc_o == exp_pc)
              else raise_error($sformatf("Mismatch at %0t: pc %h, expected %h",
                                         $time, fetch_pc_o, exp_pc));
            assert (fetch_instr_o == ref_instr(exp_pc, raw))
              else raise_error($sformatf("Mismatch at %0t: instr %h at pc %h, expected %h",
                                         $time, fetch_instr_o, exp_pc,
                                         ref_instr(exp_pc, raw)));
            bubble_due = ref_taken(raw);
            exp_pc     = ref_next_pc(exp_pc, raw);
          end else if (miss_o) begin
            assert (!bubble_due && !exp_hit)
              else raise_error($sformatf("Mismatch at %0t: unexpected miss at pc %h",
                                         $time, exp_pc));
            active = 1'b0;
            mstate = icache_pkg::MISS;
          end else begin
            assert (bubble_due)
              else raise_error($sformatf("Mismatch at %0t: no fetch for pc %h", $time, exp_pc));
            bubble_due = 1'b0;
          end
        end
        // next state from this cycle's strobes
        case (mstate)
          icache_pkg::IDLE: begin
            if (start_i) begin
              mstate     = icache_pkg::RUN;
              active     = 1'b1;
              bubble_due = 1'b1;
              exp_pc     = start_pc_i;
            end
          end
          icache_pkg::RUN: begin
            if (stop_i) begin
              mstate = icache_pkg::IDLE;
              active = 1'b0;
            end
          end
          default: begin
            if (stop_i) begin
              mstate = icache_pkg::IDLE;
            end
          end
        endcase
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
        raise_error($sformatf("timeout: the run did not end within %0d cycles", CYCLE_LIMIT));
      end
    end
  end

  initial begin : stimulus
    void'($urandom(32'hbf274091));
    rst_i        = 1'b1;
    load_en_i    = 1'b0;
    load_addr_i  = '0;
    load_instr_i = '0;
    start_i      = 1'b0;
    start_pc_i   = '0;
    stop_i       = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (!fetch_valid_o && !miss_o && !busy_o)
      else raise_error("outputs not low after reset");
    @(posedge clk_i);
    #1;

    // straight-line program, no jumps
    fill_cache(6'h04, 6'h04);
    start_at(12'h100);
    wait_fetches(20);
    stop_run();

    // jumps across the 0x400 word boundary
    fill_cache(6'h10, 6'h0f);
    load_word(12'h3e4, make_branch(8));
    load_word(12'h3e8, make_jal(28));
    load_word(12'h408, make_branch(-24));
    load_word(12'h3f2, make_branch(3));
    load_word(12'h3f4, make_jal(24));
    load_word(12'h410, make_branch(-6));
    load_word(12'h40b, make_jal(9));
    load_word(12'h414, make_jal(-28));
    // huge positive offset that wraps back by 16 words with a carry out
    load_word(12'h3fc, make_jal(32'h3fff0));
    start_at(12'h3e0);
    wait_fetches(45);
    stop_run();

    // PC wrap, backward JAL below zero, then a branch into a foreign tag
    fill_cache(6'h00, 6'h3f);
    load_word(12'h004, make_jal(-16));
    load_word(12'hff8, make_branch(-30));
    start_at(12'hffa);
    wait_miss();
    stop_run();
    for (int a = 12'hfda; a < 12'hfe0; a++) begin
      load_word(PCW'(a), rand_plain());
    end
    start_at(12'hffa);
    wait_fetches(40);
    stop_run();

    repeat (3) @(posedge clk_i);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
icache_pkg.sv
icache_fill_if.sv
jump_predecode.sv
icache_array.sv
icache.sv
pc_counter.sv
fetch_ctrl.sv
icache_fetch_top.sv
tb_icache_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_icache_fetch -f tb.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi

if [ "$status" -ne 0 ] || ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a pass result"
  exit 1
fi
